// File: Bender.yml
package:
  name: chip_bridge

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bridgePkg.sv
      - hw/byteLaneDecode.sv
      - hw/registerCycle.sv
      - hw/chipRamCycle.sv
      - hw/transferAck.sv
      - hw/bufferControl.sv
      - hw/chipBridgeTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/chipBridgeTb.sv

// File: filelist.f
+incdir+hw
hw/bridgePkg.sv
hw/byteLaneDecode.sv
hw/registerCycle.sv
hw/chipRamCycle.sv
hw/transferAck.sv
hw/bufferControl.sv
hw/chipBridgeTop.sv
test/chipBridgeTb.sv

// File: hw/bridgePkg.sv
// Shared types of the 68040 chipset bridge
// SIZ encoding follows the 68040 bus, SIZ1 in bit 1 and SIZ0 in bit 0
// Lane masks are active low, UU in bit 3 down to LL in bit 0
package bridgePkg;

    ///////////////////////////////////////////////////////////////////////
    // Transfer size
    ///////////////////////////////////////////////////////////////////////

    // 68040 SIZ pins
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } xferSize;

    ///////////////////////////////////////////////////////////////////////
    // Byte lanes
    ///////////////////////////////////////////////////////////////////////

    // Active low enables, one bit per data byte lane
    typedef logic [3:0] laneMask;

    // Bit positions inside a laneMask
    localparam int laneUU = 3;
    localparam int laneUM = 2;
    localparam int laneLM = 1;
    localparam int laneLL = 0;

    // All lanes off
    localparam laneMask lanesOff = 4'b1111;

endpackage

// File: hw/bridge_cfg.svh
// Timing constants of the chipset bridge, all counted in clk40 cycles
// Each value must be at least 1; the counters are sized from them
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// Cycles the 68000 strobes stay low in register space
`define REG_HOLD_CYCLES 12

// Consecutive cycles with nCasL and nCasU both high
// before Agnus is considered off the chip RAM bus
`define AGNUS_IDLE_CYCLES 2

// Cycles nCrcs is low up to and including the first beat
`define RAM_ACCESS_CYCLES 6

`endif

// File: hw/bufferControl.sv
// Data buffer enables and direction for the chipset data paths
// Direction is held from tsN until the next transfer
`timescale 1ns/1ps

module bufferControl (
    input  logic clk40,
    input  logic arstN,
    input  logic tsN,
    input  logic rnW,
    input  logic nAs,
    input  logic nCrcs,
    output logic nVbEn,
    output logic nDbEn,
    output logic dataDir,
    output logic nWe
);

    logic nAsDly;

    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            dataDir <= 1'b1;
            nAsDly  <= 1'b1;
        end else begin
            // High drives data towards the CPU
            if (!tsN) begin
                dataDir <= rnW;
            end
            nAsDly <= nAs;
        end
    end

    // Register buffer stays open one cycle past nAs for hold time
    assign nVbEn = nAs & nAsDly;

    // Chip RAM buffer follows the select
    assign nDbEn = nCrcs;

    // Write enable only on CPU writes
    assign nWe = nCrcs | dataDir;

endmodule

// File: hw/byteLaneDecode.sv
// Byte lane decode for 68040 transfers
// Size and address are only sampled while tsN is low
// Line transfers enable all four lanes, like a long
`timescale 1ns/1ps

module byteLaneDecode (
    input  logic                clk40,
    input  logic                arstN,
    input  logic                tsN,
    input  bridgePkg::xferSize  siz,
    input  logic [1:0]          a,
    output bridgePkg::laneMask  lanes
);

    bridgePkg::laneMask laneNext;

    ///////////////////////////////////////////////////////////////////////
    // Lane rule
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        case (siz)
            // Word picks the upper or lower half by A1
            bridgePkg::sizeWord: begin
                laneNext = a[1] ? 4'b1100 : 4'b0011;
            end
            // Byte walks from UU at offset 0 down to LL at offset 3
            bridgePkg::sizeByte: begin
                laneNext = ~(4'b1000 >> a);
            end
            // Long and line
            default: begin
                laneNext = 4'b0000;
            end
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // Lane register
    ///////////////////////////////////////////////////////////////////////

    // Held until the next transfer start
    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            lanes <= bridgePkg::lanesOff;
        end else if (!tsN) begin
            lanes <= laneNext;
        end
    end

endmodule

// File: hw/chipBridgeTop.sv
// 68040 to Amiga chipset bridge, register cycles and chip RAM cycles
// All inputs except c1 must be synchronous to clk40
// One transfer at a time, a new tsN only after the last nTa
`timescale 1ns/1ps

module chipBridgeTop (
    input  logic               clk40,
    input  logic               arstN,
    input  logic               tsN,
    input  logic               rnW,
    input  bridgePkg::xferSize siz,
    input  logic [1:0]         a,
    input  logic               nRegSpace,
    input  logic               nRamSpace,
    input  logic               c1,
    input  logic               nCasL,
    input  logic               nCasU,
    output logic               nUube,
    output logic               nUmbe,
    output logic               nLmbe,
    output logic               nLlbe,
    output logic               nAs,
    output logic               nUds,
    output logic               nLds,
    output logic               nRegEn,
    output logic               nCrcs,
    output logic               nWe,
    output logic               nTa,
    output logic               nTbi,
    output logic               nVbEn,
    output logic               nDbEn,
    output logic               dataDir
);

    bridgePkg::laneMask lanes;
    logic               regTa;
    logic               ramTa;

    // Lane enables to the pins
    assign nUube = lanes[bridgePkg::laneUU];
    assign nUmbe = lanes[bridgePkg::laneUM];
    assign nLmbe = lanes[bridgePkg::laneLM];
    assign nLlbe = lanes[bridgePkg::laneLL];

    ///////////////////////////////////////////////////////////////////////
    // Instances
    ///////////////////////////////////////////////////////////////////////

    byteLaneDecode byteLaneDecode_i (
        .clk40 (clk40),
        .arstN (arstN),
        .tsN   (tsN),
        .siz   (siz),
        .a     (a),
        .lanes (lanes)
    );

    registerCycle registerCycle_i (
        .clk40     (clk40),
        .arstN     (arstN),
        .tsN       (tsN),
        .nRegSpace (nRegSpace),
        .c1        (c1),
        .lanes     (lanes),
        .nAs       (nAs),
        .nUds      (nUds),
        .nLds      (nLds),
        .nRegEn    (nRegEn),
        .regTa     (regTa)
    );

    chipRamCycle chipRamCycle_i (
        .clk40     (clk40),
        .arstN     (arstN),
        .tsN       (tsN),
        .nRamSpace (nRamSpace),
        .siz       (siz),
        .nCasL     (nCasL),
        .nCasU     (nCasU),
        .nCrcs     (nCrcs),
        .ramTa     (ramTa)
    );

    transferAck transferAck_i (
        .clk40     (clk40),
        .arstN     (arstN),
        .tsN       (tsN),
        .nRegSpace (nRegSpace),
        .siz       (siz),
        .regTa     (regTa),
        .ramTa     (ramTa),
        .nTa       (nTa),
        .nTbi      (nTbi)
    );

    bufferControl bufferControl_i (
        .clk40   (clk40),
        .arstN   (arstN),
        .tsN     (tsN),
        .rnW     (rnW),
        .nAs     (nAs),
        .nCrcs   (nCrcs),
        .nVbEn   (nVbEn),
        .nDbEn   (nDbEn),
        .dataDir (dataDir),
        .nWe     (nWe)
    );

endmodule

// File: hw/chipRamCycle.sv
// Chip RAM access from the CPU side
// Waits for a quiet Agnus before selecting chip RAM, so latency varies
// A line transfer gives four back to back beats and all others one beat
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module chipRamCycle (
    input  logic               clk40,
    input  logic               arstN,
    input  logic               tsN,
    input  logic               nRamSpace,
    input  bridgePkg::xferSize siz,
    input  logic               nCasL,
    input  logic               nCasU,
    output logic               nCrcs,
    output logic               ramTa
);

    localparam int idleWidth = $clog2(`AGNUS_IDLE_CYCLES + 1);
    localparam int accWidth  = (`RAM_ACCESS_CYCLES > 1) ? $clog2(`RAM_ACCESS_CYCLES) : 1;

    typedef enum logic [1:0] {
        ramIdle,
        agnusWait,
        access,
        burst
    } ramState;

    ramState              state;
    logic                 isLine;
    logic [idleWidth-1:0] idleCnt;
    logic                 agnusFree;
    logic [accWidth-1:0]  accCnt;
    logic                 accDone;
    logic [1:0]           beatCnt;

    ///////////////////////////////////////////////////////////////////////
    // Agnus idle detect
    ///////////////////////////////////////////////////////////////////////

    // Any CAS low restarts the count
    // Count saturates once Agnus is free
    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            idleCnt <= '0;
        end else if (!nCasL || !nCasU) begin
            idleCnt <= '0;
        end else if (!agnusFree) begin
            idleCnt <= idleCnt + 1'b1;
        end
    end

    assign agnusFree = (idleCnt == idleWidth'(`AGNUS_IDLE_CYCLES));

    ///////////////////////////////////////////////////////////////////////
    // Access sequencer
    ///////////////////////////////////////////////////////////////////////

    assign accDone = (accCnt == accWidth'(`RAM_ACCESS_CYCLES - 1));

    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            state   <= ramIdle;
            isLine  <= 1'b0;
            accCnt  <= '0;
            beatCnt <= 2'd0;
        end else begin
            case (state)
                ramIdle: begin
                    if (!tsN && !nRamSpace) begin
                        state  <= agnusWait;
                        isLine <= (siz == bridgePkg::sizeLine);
                    end
                end
                agnusWait: begin
                    if (agnusFree) begin
                        state  <= access;
                        accCnt <= '0;
                    end
                end
                access: begin
                    // First beat lands on the last access cycle
                    if (accDone) begin
                        state   <= isLine ? burst : ramIdle;
                        beatCnt <= 2'd1;
                    end else begin
                        accCnt <= accCnt + 1'b1;
                    end
                end
                default: begin
                    // Remaining three beats of a line
                    if (beatCnt == 2'd3) begin
                        state <= ramIdle;
                    end
                    beatCnt <= beatCnt + 1'b1;
                end
            endcase
        end
    end

    assign nCrcs = ~((state == access) | (state == burst));
    assign ramTa = ((state == access) & accDone) | (state == burst);

    ///////////////////////////////////////////////////////////////////////
    // Checks
    ///////////////////////////////////////////////////////////////////////

    // First beat on the last access cycle while nCrcs is still low
    beatInsideSelect: assert property (
        @(posedge clk40) disable iff (!arstN)
            $fell(nCrcs) |-> ##(`RAM_ACCESS_CYCLES - 1) (ramTa && !nCrcs)
    ) else $error("chipRamCycle: first beat not on the last access cycle of nCrcs");

    // Next transfer only after the last nTa
    noStartWhileBusy: assert property (
        @(posedge clk40) disable iff (!arstN) !tsN |-> (state == ramIdle)
    ) else $error("chipRamCycle: tsN while a chip RAM cycle is running");

endmodule

// File: hw/registerCycle.sv
// 68000 style register cycle towards the chipset
// C1 is asynchronous here and passes a two flop synchronizer
// Start latency depends on where C1 is when tsN arrives
// Line transfers are run as a long, retry is signalled by transferAck
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module registerCycle (
    input  logic               clk40,
    input  logic               arstN,
    input  logic               tsN,
    input  logic               nRegSpace,
    input  logic               c1,
    input  bridgePkg::laneMask lanes,
    output logic               nAs,
    output logic               nUds,
    output logic               nLds,
    output logic               nRegEn,
    output logic               regTa
);

    localparam int holdWidth = (`REG_HOLD_CYCLES > 1) ? $clog2(`REG_HOLD_CYCLES) : 1;

    typedef enum logic [1:0] {
        idle,
        waitPhase,
        strobe,
        ack
    } regState;

    regState              state;
    logic [1:0]           c1Sync;
    logic                 c1Prev;
    logic                 c1Rise;
    logic [holdWidth-1:0] holdCnt;
    logic                 holdDone;
    logic                 strobeOn;

    ///////////////////////////////////////////////////////////////////////
    // C1 synchronizer and edge detect
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            c1Sync <= 2'b00;
            c1Prev <= 1'b0;
        end else begin
            c1Sync <= {c1Sync[0], c1};
            c1Prev <= c1Sync[1];
        end
    end

    assign c1Rise = c1Sync[1] & ~c1Prev;

    ///////////////////////////////////////////////////////////////////////
    // Cycle FSM
    ///////////////////////////////////////////////////////////////////////

    assign holdDone = (holdCnt == holdWidth'(`REG_HOLD_CYCLES - 1));

    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            state   <= idle;
            holdCnt <= '0;
        end else begin
            case (state)
                idle: begin
                    // Only our own address space starts a cycle
                    if (!tsN && !nRegSpace) begin
                        state <= waitPhase;
                    end
                end
                waitPhase: begin
                    // Align strobe start to the chipset phase
                    if (c1Rise) begin
                        state   <= strobe;
                        holdCnt <= '0;
                    end
                end
                strobe: begin
                    if (holdDone) begin
                        state <= ack;
                    end else begin
                        holdCnt <= holdCnt + 1'b1;
                    end
                end
                default: begin
                    // Strobes are up again, one ack beat then done
                    state <= idle;
                end
            endcase
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Strobes
    ///////////////////////////////////////////////////////////////////////

    assign strobeOn = (state == strobe);

    assign nAs    = ~strobeOn;
    assign nRegEn = ~strobeOn;

    // Upper data strobe covers the even bytes of each word
    assign nUds = ~(strobeOn & (~lanes[bridgePkg::laneUU] | ~lanes[bridgePkg::laneLM]));
    // Lower data strobe covers the odd bytes
    assign nLds = ~(strobeOn & (~lanes[bridgePkg::laneUM] | ~lanes[bridgePkg::laneLL]));

    // Pulse in the cycle the strobes rise
    assign regTa = (state == ack);

    ///////////////////////////////////////////////////////////////////////
    // Checks
    ///////////////////////////////////////////////////////////////////////

    // CPU must wait for nTa before the next transfer start
    noStartWhileBusy: assert property (
        @(posedge clk40) disable iff (!arstN) !tsN |-> (state == idle)
    ) else $error("registerCycle: tsN while a register cycle is running");

endmodule

// File: hw/transferAck.sv
// Merges the register and chip RAM acknowledges for the 68040
// nTa and nTbi are registered, so they trail the pulses by one cycle
// nTbi only asserts for a line to register space
`timescale 1ns/1ps

module transferAck (
    input  logic               clk40,
    input  logic               arstN,
    input  logic               tsN,
    input  logic               nRegSpace,
    input  bridgePkg::xferSize siz,
    input  logic               regTa,
    input  logic               ramTa,
    output logic               nTa,
    output logic               nTbi
);

    logic regLine;

    // Line to register space, CPU has to retry as singles
    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            regLine <= 1'b0;
        end else if (!tsN) begin
            regLine <= !nRegSpace && (siz == bridgePkg::sizeLine);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Acknowledge outputs
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or negedge arstN) begin
        if (!arstN) begin
            nTa  <= 1'b1;
            nTbi <= 1'b1;
        end else begin
            nTa  <= ~(regTa | ramTa);
            // Burst inhibit together with the single ack
            nTbi <= ~(regTa & regLine);
        end
    end

    // Both cycles cannot run at once
    singleSource: assert property (
        @(posedge clk40) disable iff (!arstN) !(regTa && ramTa)
    ) else $error("transferAck: register and chip RAM ack in one cycle");

endmodule

// File: test/chipBridgeTb.sv
// Directed testbench for the 68040 chipset bridge
// Inputs change with non-blocking assignments on the rising clk40 edge
// Outputs are sampled on the falling edge, where they are settled
// c1 toggles every 5 cycles; Agnus busy time and sizes come from an LFSR
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module chipBridgeTb;

    // Two sync flops plus the edge register
    localparam int c1Latency    = 3;
    localparam int numTransfers = 21;
    localparam int worstCycles  = 40;
    localparam int timeoutLimit = numTransfers * worstCycles + 10;

    logic               clk40;
    logic               arstN;
    logic               tsN;
    logic               rnW;
    bridgePkg::xferSize siz;
    logic [1:0]         a;
    logic               nRegSpace;
    logic               nRamSpace;
    logic               c1;
    logic               nCasL;
    logic               nCasU;
    logic               nUube;
    logic               nUmbe;
    logic               nLmbe;
    logic               nLlbe;
    logic               nAs;
    logic               nUds;
    logic               nLds;
    logic               nRegEn;
    logic               nCrcs;
    logic               nWe;
    logic               nTa;
    logic               nTbi;
    logic               nVbEn;
    logic               nDbEn;
    logic               dataDir;

    int          cycleCnt    = 0;
    int          c1Div       = 0;
    int          c1RiseCycle = 0;
    logic [31:0] lfsr        = 32'h570b6ddd;

    chipBridgeTop chipBridgeTop_i (
        .clk40     (clk40),
        .arstN     (arstN),
        .tsN       (tsN),
        .rnW       (rnW),
        .siz       (siz),
        .a         (a),
        .nRegSpace (nRegSpace),
        .nRamSpace (nRamSpace),
        .c1        (c1),
        .nCasL     (nCasL),
        .nCasU     (nCasU),
        .nUube     (nUube),
        .nUmbe     (nUmbe),
        .nLmbe     (nLmbe),
        .nLlbe     (nLlbe),
        .nAs       (nAs),
        .nUds      (nUds),
        .nLds      (nLds),
        .nRegEn    (nRegEn),
        .nCrcs     (nCrcs),
        .nWe       (nWe),
        .nTa       (nTa),
        .nTbi      (nTbi),
        .nVbEn     (nVbEn),
        .nDbEn     (nDbEn),
        .dataDir   (dataDir)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock, chipset phase and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk40 = 1'b0;
        forever #50 clk40 = ~clk40;
    end

    // C1 period is 10 cycles, rise time kept for the latency check
    always @(posedge clk40) begin
        cycleCnt <= cycleCnt + 1;
        if (c1Div == 4) begin
            c1Div <= 0;
            c1    <= ~c1;
            if (!c1) begin
                c1RiseCycle <= cycleCnt + 1;
            end
        end else begin
            c1Div <= c1Div + 1;
        end
    end

    always @(negedge clk40) begin
        if (cycleCnt >= timeoutLimit) begin
            $display("Timeout: the DUT stopped finishing transfers");
            $display("Regression failed");
            $fatal(1, "Simulation hung");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Expected lanes UU UM LM LL, active low
    function automatic logic [3:0] expectLanes(input logic [1:0] s, input logic [1:0] addr);
        logic [3:0] m;
        if (s == bridgePkg::sizeByte) begin
            case (addr)
                2'd0:    m = 4'b0111;
                2'd1:    m = 4'b1011;
                2'd2:    m = 4'b1101;
                default: m = 4'b1110;
            endcase
        end else if (s == bridgePkg::sizeWord) begin
            m = addr[1] ? 4'b1100 : 4'b0011;
        end else begin
            m = 4'b0000;
        end
        return m;
    endfunction

    task automatic startTransfer(input logic toRam, input logic [1:0] s,
                                 input logic [1:0] addr, input logic dir);
        @(posedge clk40);
        tsN       <= 1'b0;
        siz       <= bridgePkg::xferSize'(s);
        a         <= addr;
        rnW       <= dir;
        nRegSpace <= toRam;
        nRamSpace <= !toRam;
        @(posedge clk40);
        tsN       <= 1'b1;
        nRegSpace <= 1'b1;
        nRamSpace <= 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Transfer runners
    //////////////////////////////////////////////////////////////////////

    task automatic regTransfer(input logic [1:0] s, input logic [1:0] addr, input logic dir);
        logic [3:0] lanesExp;
        logic       udsExp;
        logic       ldsExp;
        logic       tbiExp;
        lanesExp = expectLanes(s, addr);
        // Upper strobe for UU or LM, lower for UM or LL
        udsExp = lanesExp[3] & lanesExp[1];
        ldsExp = lanesExp[2] & lanesExp[0];
        tbiExp = (s != bridgePkg::sizeLine);
        startTransfer(1'b0, s, addr, dir);
        @(negedge clk40);
        checkValue("nUube", nUube, lanesExp[3]);
        checkValue("nUmbe", nUmbe, lanesExp[2]);
        checkValue("nLmbe", nLmbe, lanesExp[1]);
        checkValue("nLlbe", nLlbe, lanesExp[0]);
        // Waiting for the C1 edge
        while (nAs) begin
            checkValue("nUds", nUds, 1'b1);
            checkValue("nTa", nTa, 1'b1);
            @(negedge clk40);
        end
        checkValue("c1 rise to nAs", cycleCnt - c1RiseCycle, c1Latency);
        repeat (`REG_HOLD_CYCLES) begin
            checkValue("nAs", nAs, 1'b0);
            checkValue("nUds", nUds, udsExp);
            checkValue("nLds", nLds, ldsExp);
            checkValue("nRegEn", nRegEn, 1'b0);
            checkValue("nVbEn", nVbEn, 1'b0);
            checkValue("nTa", nTa, 1'b1);
            checkValue("dataDir", dataDir, dir);
            @(negedge clk40);
        end
        // Strobes up, buffer still open
        checkValue("nAs", nAs, 1'b1);
        checkValue("nUds", nUds, 1'b1);
        checkValue("nLds", nLds, 1'b1);
        checkValue("nRegEn", nRegEn, 1'b1);
        checkValue("nVbEn", nVbEn, 1'b0);
        checkValue("nTa", nTa, 1'b1);
        @(negedge clk40);
        checkValue("nTa", nTa, 1'b0);
        checkValue("nTbi", nTbi, tbiExp);
        checkValue("nVbEn", nVbEn, 1'b1);
        @(negedge clk40);
        checkValue("nTa", nTa, 1'b1);
        checkValue("nTbi", nTbi, 1'b1);
    endtask

    task automatic ramTransfer(input logic [1:0] s, input logic [1:0] addr, input logic dir,
                               input int busy, input logic useCasU);
        int   beats;
        int   highCnt;
        logic crcsExp;
        logic taExp;
        beats = (s == bridgePkg::sizeLine) ? 4 : 1;
        // Agnus owns the bus before the request arrives
        @(posedge clk40);
        if (useCasU) begin
            nCasU <= 1'b0;
        end else begin
            nCasL <= 1'b0;
        end
        startTransfer(1'b1, s, addr, dir);
        repeat (busy) begin
            @(negedge clk40);
            checkValue("nCrcs", nCrcs, 1'b1);
            @(posedge clk40);
        end
        nCasL <= 1'b1;
        nCasU <= 1'b1;
        highCnt = 0;
        @(negedge clk40);
        while (nCrcs) begin
            checkValue("nTa", nTa, 1'b1);
            highCnt++;
            @(negedge clk40);
        end
        // Idle count plus its register stage
        checkValue("Agnus idle cycles", highCnt, `AGNUS_IDLE_CYCLES + 1);
        for (int k = 0; k <= `RAM_ACCESS_CYCLES + beats; k++) begin
            crcsExp = !(k <= `RAM_ACCESS_CYCLES + beats - 2);
            taExp   = !(k >= `RAM_ACCESS_CYCLES && k <= `RAM_ACCESS_CYCLES + beats - 1);
            checkValue("nCrcs", nCrcs, crcsExp);
            checkValue("nTa", nTa, taExp);
            checkValue("nTbi", nTbi, 1'b1);
            checkValue("nDbEn", nDbEn, crcsExp);
            checkValue("nWe", nWe, crcsExp | dir);
            checkValue("dataDir", dataDir, dir);
            checkValue("nAs", nAs, 1'b1);
            @(negedge clk40);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic resetIdleTest();
        @(negedge clk40);
        checkValue("nAs", nAs, 1'b1);
        checkValue("nUds", nUds, 1'b1);
        checkValue("nLds", nLds, 1'b1);
        checkValue("nRegEn", nRegEn, 1'b1);
        checkValue("nCrcs", nCrcs, 1'b1);
        checkValue("nTa", nTa, 1'b1);
        checkValue("nTbi", nTbi, 1'b1);
        checkValue("nVbEn", nVbEn, 1'b1);
        checkValue("nDbEn", nDbEn, 1'b1);
        checkValue("nWe", nWe, 1'b1);
        checkValue("lanes", {nUube, nUmbe, nLmbe, nLlbe}, 4'hf);
    endtask

    task automatic laneDecodeTest();
        logic [31:0] s;
        logic [31:0] addr;
        logic [31:0] dir;
        repeat (8) begin
            drawBits(2, s);
            drawBits(2, addr);
            drawBits(1, dir);
            regTransfer(s[1:0], addr[1:0], dir[0]);
        end
    endtask

    task automatic registerCycleTest();
        regTransfer(bridgePkg::sizeWord, 2'd2, 1'b1);
        regTransfer(bridgePkg::sizeByte, 2'd1, 1'b0);
        regTransfer(bridgePkg::sizeLong, 2'd0, 1'b1);
    endtask

    // Runs as a long with burst inhibit
    task automatic lineRegisterTest();
        regTransfer(bridgePkg::sizeLine, 2'd0, 1'b1);
        regTransfer(bridgePkg::sizeLine, 2'd2, 1'b0);
    endtask

    task automatic chipRamTest();
        logic [31:0] s;
        logic [31:0] addr;
        logic [31:0] dir;
        logic [31:0] busy;
        logic [31:0] casSel;
        ramTransfer(bridgePkg::sizeLong, 2'd0, 1'b1, 3, 1'b0);
        ramTransfer(bridgePkg::sizeLine, 2'd0, 1'b1, 5, 1'b1);
        ramTransfer(bridgePkg::sizeLine, 2'd0, 1'b0, 1, 1'b0);
        ramTransfer(bridgePkg::sizeWord, 2'd2, 1'b0, 2, 1'b1);
        repeat (4) begin
            drawBits(2, s);
            drawBits(2, addr);
            drawBits(1, dir);
            drawBits(4, busy);
            drawBits(1, casSel);
            ramTransfer(s[1:0], addr[1:0], dir[0], busy + 1, casSel[0]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        arstN     = 1'b0;
        tsN       = 1'b1;
        rnW       = 1'b1;
        siz       = bridgePkg::sizeLong;
        a         = 2'd0;
        nRegSpace = 1'b1;
        nRamSpace = 1'b1;
        c1        = 1'b0;
        nCasL     = 1'b1;
        nCasU     = 1'b1;
        repeat (2) @(posedge clk40);
        arstN <= 1'b1;
        resetIdleTest();
        laneDecodeTest();
        registerCycleTest();
        lineRegisterTest();
        chipRamTest();
        $display("Regression passed");
        $finish;
    end

endmodule
